//--- src/uart_pkg.sv
//####################
// uart shared definitions
// register map, widths, control word layout and status bits
//####################

package uart_pkg;

    localparam int data_width = 32;         // wishbone data bus
    localparam int addr_width = 4;          // byte address into the register map
    localparam int comp_width = 16;         // baud compare

    typedef logic [7:0] byte_t;

    // word offsets of the register map
    localparam logic [addr_width-1:0] cr_addr = 4'h0;   // control
    localparam logic [addr_width-1:0] tx_addr = 4'h4;   // transmit data
    localparam logic [addr_width-1:0] rx_addr = 4'h8;   // receive data
    localparam logic [addr_width-1:0] sr_addr = 4'hc;   // status

    typedef struct packed {
        logic [comp_width-1:0] comp;        // bit period minus one
        logic [13:0]           rsvd;        // reads as zero
        logic                  rx_en;
        logic                  tx_en;
    } uart_cr_fields_t;

    // control word, raw on the bus and decoded by the hardware
    typedef union packed {
        logic [data_width-1:0] raw;
        uart_cr_fields_t       f;
    } uart_cr_u;

    localparam int sr_tx_busy  = 0;         // frame in flight
    localparam int sr_rx_ready = 1;         // unread byte in rx

endpackage

//--- src/uart_ctrl_if.sv
//####################
// uart control interface
// links the register block to the serial engines
//####################

`timescale 1ns/1ps

interface uart_ctrl_if
(
    input logic clk,
    input logic resetn
);

    logic                            tx_en;
    logic                            rx_en;
    logic [uart_pkg::comp_width-1:0] comp;      // shared baud compare
    uart_pkg::byte_t                 tx_data;
    logic                            tx_start;  // one cycle request
    logic                            tx_busy;
    uart_pkg::byte_t                 rx_data;
    logic                            rx_valid;  // one cycle strobe

    modport regs
    (
        input  clk, resetn,
        output tx_en, rx_en, comp, tx_data, tx_start,
        input  tx_busy, rx_data, rx_valid
    );

    modport tx
    (
        input  clk, resetn,
        input  tx_en, comp, tx_data, tx_start,
        output tx_busy
    );

    modport rx
    (
        input  clk, resetn,
        input  rx_en, comp,
        output rx_data, rx_valid
    );

endinterface

//--- src/uart_transmitter.sv
//####################
// uart transmitter
// shifts one byte out as an 8N1 frame, LSB first
// each bit lasts comp+1 clocks
//####################

`timescale 1ns/1ps

module uart_transmitter
(
    input  logic    clk,
    input  logic    resetn,
    uart_ctrl_if.tx ctrl,
    output logic    uart_tx
);

    logic [9:0]                      frame_q;   // stop, data, start
    logic [3:0]                      bit_cnt;   // bits already sent
    logic [uart_pkg::comp_width-1:0] baud_cnt;
    logic                            busy;
    logic                            baud_tick;

    // >= so that a smaller comp written mid-frame cannot stall the count
    assign baud_tick = baud_cnt >= ctrl.comp;

    assign uart_tx      = frame_q[0];           // straight from a flop
    assign ctrl.tx_busy = busy;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            frame_q  <= '1;                     // line idles high
            bit_cnt  <= '0;
            baud_cnt <= '0;
            busy     <= 1'b0;
        end
        else if (!ctrl.tx_en)
        begin
            frame_q  <= '1;                     // abort, back to idle
            bit_cnt  <= '0;
            baud_cnt <= '0;
            busy     <= 1'b0;
        end
        else if (!busy)
        begin
            bit_cnt  <= '0;
            baud_cnt <= '0;
            if (ctrl.tx_start)
            begin
                frame_q <= {1'b1, ctrl.tx_data, 1'b0};
                busy    <= 1'b1;
            end
        end
        else if (baud_tick)
        begin
            baud_cnt <= '0;
            frame_q  <= {1'b1, frame_q[9:1]};   // fill with idle ones
            bit_cnt  <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9)
                busy <= 1'b0;                   // stop bit has held its period
        end
        else
        begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

//--- src/uart_receiver.sv
//####################
// uart receiver
// waits for a start bit, samples every bit at mid-period
// and strobes the received byte for one cycle
//####################

`timescale 1ns/1ps

module uart_receiver
(
    input  logic    clk,
    input  logic    resetn,
    uart_ctrl_if.rx ctrl,
    input  logic    uart_rx
);

    typedef enum logic
    {
        st_wait,
        st_receive
    } rx_state_t;

    rx_state_t                       state;
    rx_state_t                       next_state;
    logic [1:0]                      rx_sync;   // line resync
    logic                            rx_line;
    uart_pkg::byte_t                 shift_reg;
    logic [3:0]                      bit_cnt;
    logic [uart_pkg::comp_width-1:0] baud_cnt;
    logic                            rx_valid_q;
    logic                            start_seen;
    logic                            frame_done;
    logic                            mid_bit;

    assign rx_line    = rx_sync[1];
    assign start_seen = !rx_line;
    assign frame_done = bit_cnt == 4'd9;        // start plus eight data bits
    assign mid_bit    = baud_cnt == (ctrl.comp >> 1);

    assign ctrl.rx_data  = shift_reg;
    assign ctrl.rx_valid = rx_valid_q;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            rx_sync <= 2'b11;                   // idle high
        else
            rx_sync <= {rx_sync[0], uart_rx};
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= st_wait;
        else if (!ctrl.rx_en)
            state <= st_wait;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            st_wait    : if (start_seen) next_state = st_receive;
            st_receive : if (frame_done) next_state = st_wait;
            default    : next_state = st_wait;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            bit_cnt    <= '0;
            baud_cnt   <= '0;
            rx_valid_q <= 1'b0;
        end
        else if (!ctrl.rx_en)
        begin
            bit_cnt    <= '0;
            baud_cnt   <= '0;
            rx_valid_q <= 1'b0;
        end
        else
        begin
            case (state)
                st_wait :
                begin
                    bit_cnt    <= '0;
                    baud_cnt   <= '0;
                    rx_valid_q <= 1'b0;
                end
                st_receive :
                begin
                    baud_cnt <= baud_cnt + 1'b1;
                    if (baud_cnt >= ctrl.comp)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 4'd1;
                    end
                    if (frame_done)
                        rx_valid_q <= 1'b1;     // cleared again in wait
                end
                default : rx_valid_q <= 1'b0;
            endcase
        end
    end

    // shift in from the top, the start bit falls out after eight data bits
    always_ff @(posedge clk)
    begin
        if (ctrl.rx_en && state == st_receive && mid_bit && !frame_done)
            shift_reg <= {rx_line, shift_reg[7:1]};
    end

endmodule

//--- src/uart_wb_regs.sv
//####################
// uart register block
// wishbone classic slave with control, tx, rx and status
//####################

`timescale 1ns/1ps

module uart_wb_regs
#(
    parameter logic [uart_pkg::comp_width-1:0] reset_comp = 16'd867
)
(
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [uart_pkg::addr_width-1:0] wb_adr,
    input  logic [uart_pkg::data_width-1:0] wb_dat_i,
    output logic [uart_pkg::data_width-1:0] wb_dat_o,
    output logic                            wb_ack,
    uart_ctrl_if.regs                       ctrl
);

    uart_pkg::uart_cr_u               cr_q;
    uart_pkg::uart_cr_u               cr_wr;      // bus word, reserved cleared
    uart_pkg::byte_t                  tx_data_q;
    uart_pkg::byte_t                  rx_data_q;
    logic                             rx_ready;
    logic                             tx_start_q;
    logic                             req;        // request not yet acked
    logic [uart_pkg::addr_width-1:0]  word_adr;
    logic                             wr_cr;
    logic                             wr_tx;
    logic                             tx_accept;
    logic                             rd_rx;
    logic [uart_pkg::data_width-1:0]  rd_data;

    assign req      = wb_cyc & wb_stb & !wb_ack;
    assign word_adr = {wb_adr[uart_pkg::addr_width-1:2], 2'b00};

    assign wr_cr     = req & wb_we & (word_adr == uart_pkg::cr_addr);
    assign wr_tx     = req & wb_we & (word_adr == uart_pkg::tx_addr);
    assign tx_accept = wr_tx & !ctrl.tx_busy;    // busy writes are dropped
    assign rd_rx     = req & !wb_we & (word_adr == uart_pkg::rx_addr);

    assign ctrl.tx_en    = cr_q.f.tx_en;
    assign ctrl.rx_en    = cr_q.f.rx_en;
    assign ctrl.comp     = cr_q.f.comp;
    assign ctrl.tx_data  = tx_data_q;
    assign ctrl.tx_start = tx_start_q;

    always_comb
    begin
        cr_wr.raw    = wb_dat_i;
        cr_wr.f.rsvd = '0;
    end

    always_comb
    begin
        rd_data = '0;
        case (word_adr)
            uart_pkg::cr_addr : rd_data = cr_q.raw;
            uart_pkg::rx_addr : rd_data[7:0] = rx_data_q;
            uart_pkg::sr_addr :
            begin
                rd_data[uart_pkg::sr_tx_busy]  = ctrl.tx_busy;
                rd_data[uart_pkg::sr_rx_ready] = rx_ready;
            end
            default : rd_data = '0;         // tx reads as zero
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wb_ack     <= 1'b0;
            wb_dat_o   <= '0;
            tx_start_q <= 1'b0;
            rx_ready   <= 1'b0;
            cr_q.raw   <= '0;
            cr_q.f.comp <= reset_comp;
        end
        else
        begin
            wb_ack     <= req;              // one cycle after the request
            tx_start_q <= tx_accept;        // lines up with ack
            if (req)
                wb_dat_o <= rd_data;
            if (wr_cr)
                cr_q <= cr_wr;
            // a new byte wins over the read that clears the flag
            if (ctrl.rx_valid)
                rx_ready <= 1'b1;
            else if (rd_rx)
                rx_ready <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_accept)
            tx_data_q <= wb_dat_i[7:0];
        if (ctrl.rx_valid)
            rx_data_q <= ctrl.rx_data;      // overrun just overwrites
    end

endmodule

//--- src/uart_top.sv
//####################
// uart peripheral top
// wishbone register block with transmitter and receiver
//####################

`timescale 1ns/1ps

module uart_top
#(
    parameter logic [uart_pkg::comp_width-1:0] reset_comp = 16'd867
)
(
    input  logic                            clk,
    input  logic                            resetn,
    // wishbone classic slave
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [uart_pkg::addr_width-1:0] wb_adr,
    input  logic [uart_pkg::data_width-1:0] wb_dat_i,
    output logic [uart_pkg::data_width-1:0] wb_dat_o,
    output logic                            wb_ack,
    // serial lines
    output logic                            uart_tx,
    input  logic                            uart_rx
);

    uart_ctrl_if ctrl_if
    (
        .clk    ( clk    ),
        .resetn ( resetn )
    );

    uart_wb_regs
    #(
        .reset_comp ( reset_comp )
    )
    uart_wb_regs_inst
    (
        .clk      ( clk      ),
        .resetn   ( resetn   ),
        .wb_cyc   ( wb_cyc   ),
        .wb_stb   ( wb_stb   ),
        .wb_we    ( wb_we    ),
        .wb_adr   ( wb_adr   ),
        .wb_dat_i ( wb_dat_i ),
        .wb_dat_o ( wb_dat_o ),
        .wb_ack   ( wb_ack   ),
        .ctrl     ( ctrl_if  )
    );

    uart_transmitter uart_transmitter_inst
    (
        .clk     ( clk     ),
        .resetn  ( resetn  ),
        .ctrl    ( ctrl_if ),
        .uart_tx ( uart_tx )
    );

    uart_receiver uart_receiver_inst
    (
        .clk     ( clk     ),
        .resetn  ( resetn  ),
        .ctrl    ( ctrl_if ),
        .uart_rx ( uart_rx )
    );

endmodule

//--- testbench/tb_clock_gen.sv
//####################
// testbench clock and reset
// 100 ns clock, reset held low for two cycles
//####################

`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic resetn
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;                       // released just after the edge
    end

endmodule

//--- testbench/uart_top_tb.sv
//####################
// uart peripheral testbench
// table of register, serial and loopback tests
//####################

`timescale 1ns/1ps

module uart_top_tb;

    localparam logic [15:0] tb_reset_comp = 16'd6;     // keeps frames short
    localparam int          num_tests     = 12;

    typedef enum logic [2:0] {op_reset, op_ctrl, op_tx, op_rx, op_rx_off, op_loop} op_t;

    typedef struct packed
    {
        op_t                             op;
        uart_pkg::byte_t                 data;
        logic [uart_pkg::comp_width-1:0] comp;
        logic [uart_pkg::data_width-1:0] exp_val;
    } vec_t;

    logic                            clk;
    logic                            resetn;
    logic                            wb_cyc;
    logic                            wb_stb;
    logic                            wb_we;
    logic [uart_pkg::addr_width-1:0] wb_adr;
    logic [uart_pkg::data_width-1:0] wb_dat_i;
    logic [uart_pkg::data_width-1:0] wb_dat_o;
    logic                            wb_ack;
    logic                            uart_tx;
    logic                            uart_rx;
    logic                            rx_drive;  // serial driver output
    logic                            loopback;
    vec_t                            tests [num_tests];
    int                              errors;

    assign uart_rx = loopback ? uart_tx : rx_drive;

    tb_clock_gen clock_gen_inst
    (
        .clk    ( clk    ),
        .resetn ( resetn )
    );

    uart_top
    #(
        .reset_comp ( tb_reset_comp )
    )
    uart_top_inst
    (
        .clk      ( clk      ),
        .resetn   ( resetn   ),
        .wb_cyc   ( wb_cyc   ),
        .wb_stb   ( wb_stb   ),
        .wb_we    ( wb_we    ),
        .wb_adr   ( wb_adr   ),
        .wb_dat_i ( wb_dat_i ),
        .wb_dat_o ( wb_dat_o ),
        .wb_ack   ( wb_ack   ),
        .uart_tx  ( uart_tx  ),
        .uart_rx  ( uart_rx  )
    );

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string what);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
            errors++;
        end
    endtask

    task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
        int cycles;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        cycles   = 0;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        while (wb_ack !== 1'b1 && cycles < 8);
        if (wb_ack !== 1'b1)
        begin
            $display("timeout at %0t ns: the slave never acknowledged", $time);
            errors++;
        end
        else
            check(32'd1, cycles, "ack latency");
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);                         // idle cycle while ack drops
        #1;
    endtask

    // 8N1, LSB first, each bit held comp+1 cycles
    task automatic send_frame(input logic [7:0] data, input int comp);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            rx_drive = frame[i];
            repeat (comp + 1) @(posedge clk);
            #1;
        end
        rx_drive = 1'b1;
    endtask

    task automatic watch_frame(input int comp, input int limit, output logic found,
                               output logic [9:0] frame, output int glitches);
        int   n;
        logic first;
        n        = 0;
        frame    = '1;
        glitches = 0;
        while (uart_tx !== 1'b0 && n < limit)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        found = uart_tx === 1'b0;
        for (int i = 0; i < 10 && found; i++)
        begin
            for (int j = 0; j <= comp; j++)
            begin
                if (j == 0)
                    first = uart_tx;
                if (j == comp / 2)
                    frame[i] = uart_tx;         // mid bit sample
                if (uart_tx !== first)
                    glitches++;                 // line moved inside one bit
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic poll_status(input logic [31:0] mask, input logic [31:0] value);
        logic [31:0] sr;
        int          n;
        n = 0;
        do
        begin
            wb_xfer(1'b0, uart_pkg::sr_addr, 32'h0, sr);
            n++;
        end
        while ((sr & mask) !== value && n < 100);
        if ((sr & mask) !== value)
        begin
            $display("timeout at %0t ns: status never reached %h under mask %h",
                     $time, value, mask);
            errors++;
        end
    endtask

    initial
    begin
        logic [31:0] rd;
        logic        found;
        logic [9:0]  frame;
        int          glitches;
        int          n;
        int          ok_cnt;
        int          bad_cnt;
        vec_t        cur;
        op_t         op;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        rx_drive = 1'b1;
        loopback = 1'b0;
        errors   = 0;
        ok_cnt   = 0;
        bad_cnt  = 0;
        void'($urandom(32'he8c867f2));
        tests[0]  = '{op_reset,  8'h00, 16'd0,    {tb_reset_comp, 16'h0000}};
        tests[1]  = '{op_ctrl,   8'hfe, 16'h1234, 32'h1234_0002};
        tests[2]  = '{op_ctrl,   8'h01, 16'habcd, 32'habcd_0001};
        tests[3]  = '{op_tx,     8'ha5, 16'd3,    32'h0000_00a5};
        tests[4]  = '{op_tx,     8'h3c, 16'd0,    32'h0000_003c};
        tests[5]  = '{op_rx,     8'h5a, 16'd4,    32'h0000_005a};
        tests[6]  = '{op_rx,     8'h81, 16'd7,    32'h0000_0081};
        tests[7]  = '{op_rx_off, 8'hff, 16'd3,    32'h0000_0000};   // status stays clear
        tests[8]  = '{op_loop,   8'h00, 16'd2,    32'h0};
        tests[9]  = '{op_loop,   8'h00, 16'd5,    32'h0};
        tests[10] = '{op_loop,   8'h00, 16'd9,    32'h0};
        tests[11] = '{op_loop,   8'h00, 16'd16,   32'h0};
        for (int i = 0; i < num_tests; i++)
        begin
            if (tests[i].op == op_loop)
            begin
                tests[i].data    = 8'($urandom);
                tests[i].exp_val = {24'h0, tests[i].data};
            end
        end
        n = 0;
        while (resetn !== 1'b1 && n < 10)
        begin
            @(posedge clk);
            n++;
        end
        if (resetn !== 1'b1)
        begin
            $display("reset was never released");
            errors++;
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < num_tests; i++)
        begin
            n   = errors;
            cur = tests[i];
            op  = cur.op;
            case (op)
                op_reset :
                begin
                    wb_xfer(1'b0, uart_pkg::cr_addr, 32'h0, rd);
                    check(cur.exp_val, rd, "control after reset");
                    wb_xfer(1'b0, uart_pkg::sr_addr, 32'h0, rd);
                    check(32'h0, rd, "status after reset");
                    check(32'h1, uart_tx, "uart_tx idle after reset");
                end
                op_ctrl :
                begin
                    // ones in the reserved field must read back as zero
                    wb_xfer(1'b1, uart_pkg::cr_addr, {cur.comp, 8'hff, cur.data}, rd);
                    wb_xfer(1'b0, uart_pkg::cr_addr, 32'h0, rd);
                    check(cur.exp_val, rd, "control readback");
                end
                op_tx :
                begin
                    wb_xfer(1'b1, uart_pkg::cr_addr, {cur.comp, 16'h0001}, rd);
                    fork
                        watch_frame(cur.comp, 40, found, frame, glitches);
                        begin
                            wb_xfer(1'b1, uart_pkg::tx_addr, {24'h0, cur.data}, rd);
                            wb_xfer(1'b0, uart_pkg::sr_addr, 32'h0, rd);
                            check(32'h1, rd, "tx_busy during frame");
                            wb_xfer(1'b1, uart_pkg::tx_addr, {24'h0, ~cur.data}, rd);
                        end
                    join
                    if (!found)
                        $display("timeout at %0t ns: no start bit on uart_tx", $time);
                    check({1'b1, cur.exp_val[7:0], 1'b0}, frame, "tx frame");
                    check(32'h0, glitches, "bit period");
                    watch_frame(cur.comp, 30 * (cur.comp + 1), found, frame, glitches);
                    check(32'h0, found, "second frame after write while busy");
                    wb_xfer(1'b0, uart_pkg::sr_addr, 32'h0, rd);
                    check(32'h0, rd, "status after frame");
                end
                op_rx :
                begin
                    wb_xfer(1'b1, uart_pkg::cr_addr, {cur.comp, 16'h0002}, rd);
                    send_frame(cur.data, cur.comp);
                    poll_status(32'h2, 32'h2);
                    wb_xfer(1'b0, uart_pkg::rx_addr, 32'h0, rd);
                    check(cur.exp_val, rd, "received byte");
                    wb_xfer(1'b0, uart_pkg::sr_addr, 32'h0, rd);
                    check(32'h0, rd, "status after rx read");
                end
                op_rx_off :
                begin
                    wb_xfer(1'b1, uart_pkg::cr_addr, {cur.comp, 16'h0000}, rd);
                    send_frame(cur.data, cur.comp);
                    // keep looking past the point where a byte would have landed
                    for (int k = 0; k <= cur.comp; k++)
                    begin
                        wb_xfer(1'b0, uart_pkg::sr_addr, 32'h0, rd);
                        check(cur.exp_val, rd, "status with rx disabled");
                    end
                end
                default :
                begin
                    loopback = 1'b1;
                    wb_xfer(1'b1, uart_pkg::cr_addr, {cur.comp, 16'h0003}, rd);
                    wb_xfer(1'b1, uart_pkg::tx_addr, {24'h0, cur.data}, rd);
                    poll_status(32'h2, 32'h2);
                    wb_xfer(1'b0, uart_pkg::rx_addr, 32'h0, rd);
                    check(cur.exp_val, rd, "loopback byte");
                    poll_status(32'h1, 32'h0);   // let the stop bit finish
                    loopback = 1'b0;
                end
            endcase
            if (errors == n)
            begin
                ok_cnt++;
                $display("test %0d %s: ok", i, op.name());
            end
            else
            begin
                bad_cnt++;
                $display("test %0d %s: mismatch", i, op.name());
            end
        end
        $display("%0d tests ok, %0d tests bad", ok_cnt, bad_cnt);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- project.f
src/uart_pkg.sv
src/uart_ctrl_if.sv
src/uart_transmitter.sv
src/uart_receiver.sv
src/uart_wb_regs.sv
src/uart_top.sv
testbench/tb_clock_gen.sv
testbench/uart_top_tb.sv

//--- Bender.yml
package:
  name: uart_wb

sources:
  - files:
      - src/uart_pkg.sv
      - src/uart_ctrl_if.sv
      - src/uart_transmitter.sv
      - src/uart_receiver.sv
      - src/uart_wb_regs.sv
      - src/uart_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/uart_top_tb.sv
